// ==== src/lcd_pkg.sv ====
package lcd_pkg;

	localparam int CLK_PER_US    = 20;
	localparam int POWERUP_US    = 500;
	localparam int INIT_PULSE_US = 10;

	localparam int WAIT_FSET_US  = 50;
	localparam int WAIT_DCTL_US  = 50;
	localparam int WAIT_CLR_US   = 200;
	localparam int WAIT_ENTRY_US = 100;

	localparam int XFER_SETUP_US = 1;  // enable low before pulse
	localparam int XFER_EHIGH_US = 14; // enable falls here
	localparam int XFER_ELOW_US  = 27; // end of enable-low half
	localparam int XFER_HOLD_US  = 50; // whole transfer

	localparam int CNT_W       = 14;
	localparam int XFER_W      = 10;
	localparam int XFER_RS_BIT = 9;
	localparam int XFER_RW_BIT = 8;
	localparam int CFG_W       = 7;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

	localparam int         ST_W     = 2;
	localparam logic [1:0] ST_PWRUP = 2'd0;
	localparam logic [1:0] ST_INIT  = 2'd1;
	localparam logic [1:0] ST_IDLE  = 2'd2;
	localparam logic [1:0] ST_XFER  = 2'd3;

	// cycle counts, sized to the counter
	localparam logic [CNT_W-1:0] POWERUP_CYC    = CNT_W'(POWERUP_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] INIT_PULSE_CYC = CNT_W'(INIT_PULSE_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] FSET_END_CYC   =
		CNT_W'((INIT_PULSE_US + WAIT_FSET_US) * CLK_PER_US);
	localparam logic [CNT_W-1:0] DCTL_END_CYC   =
		FSET_END_CYC + CNT_W'((INIT_PULSE_US + WAIT_DCTL_US) * CLK_PER_US);
	localparam logic [CNT_W-1:0] CLR_END_CYC    =
		DCTL_END_CYC + CNT_W'((INIT_PULSE_US + WAIT_CLR_US) * CLK_PER_US);
	localparam logic [CNT_W-1:0] INIT_END_CYC   =
		CLR_END_CYC + CNT_W'((INIT_PULSE_US + WAIT_ENTRY_US) * CLK_PER_US);

	localparam logic [CNT_W-1:0] XFER_SETUP_CYC = CNT_W'(XFER_SETUP_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] XFER_EHIGH_CYC = CNT_W'(XFER_EHIGH_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] XFER_HOLD_CYC  = CNT_W'(XFER_HOLD_US * CLK_PER_US);

endpackage

// ==== src/lcd_cmd_queue.sv ====
module lcd_cmd_queue
	import lcd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              xfer_valid,
	input  logic [XFER_W-1:0] xfer_word,
	output logic              xfer_ready,
	output logic              q_valid,
	input  logic              q_ready,
	output logic [XFER_W-1:0] q_word
);

	logic [XFER_W-1:0]      mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_PTR_W:0]   count;
	logic                   push;
	logic                   pop;

	assign xfer_ready = (count != (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
	assign q_valid    = (count != '0);
	assign q_word     = mem[rd_ptr];

	assign push = xfer_valid && xfer_ready;
	assign pop  = q_valid && q_ready;

	// queue storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= xfer_word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
		end
	end

endmodule

// ==== src/lcd_bus_timing.sv ====
module lcd_bus_timing
	import lcd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [CFG_W-1:0]  cfg,
	input  logic              q_valid,
	output logic              q_ready,
	input  logic [XFER_W-1:0] q_word,
	input  logic              rsp_free,
	output logic              lcd_e,
	output logic              lcd_rs,
	output logic              lcd_rw,
	output logic [7:0]        lcd_data,
	output logic              busy,
	output logic              cap_strobe
);

	logic [ST_W-1:0]   state;
	logic [ST_W-1:0]   state_nxt;
	logic [CNT_W-1:0]  cnt;
	logic [CNT_W-1:0]  cnt_nxt;
	logic [XFER_W-1:0] word_nxt;
	logic              rd_ok;
	logic              take;

	logic [CNT_W-1:0]  step_ofs;
	logic [7:0]        step_byte;

	logic              e_nxt;
	logic              rs_nxt;
	logic              rw_nxt;
	logic [7:0]        data_nxt;
	logic              strobe_nxt;

	// a read waits until the response slot is free
	assign rd_ok   = !q_word[XFER_RW_BIT] || rsp_free;
	assign q_ready = (state == ST_IDLE) && q_valid && rd_ok;
	assign take    = q_valid && q_ready;

	always_comb begin
		state_nxt = state;
		cnt_nxt   = cnt + 1'b1;
		word_nxt  = {lcd_rs, lcd_rw, lcd_data}; // hold by default
		case (state)
			ST_PWRUP: begin
				if (cnt == POWERUP_CYC - 1'b1) begin
					state_nxt = ST_INIT;
					cnt_nxt   = '0;
				end
			end
			ST_INIT: begin
				if (cnt == INIT_END_CYC - 1'b1) begin
					state_nxt = ST_IDLE;
					cnt_nxt   = '0;
				end
			end
			ST_IDLE: begin
				cnt_nxt = '0;
				if (take) begin
					state_nxt = ST_XFER;
					word_nxt  = q_word;
				end
			end
			ST_XFER: begin
				if (cnt == XFER_HOLD_CYC - 1'b1) begin
					state_nxt = ST_IDLE;
					cnt_nxt   = '0;
				end
			end
			default: begin
				state_nxt = ST_PWRUP;
				cnt_nxt   = '0;
			end
		endcase
	end

	// which init step the next count falls in
	always_comb begin
		if (cnt_nxt < FSET_END_CYC) begin
			step_ofs  = cnt_nxt;
			step_byte = {4'b0011, cfg[6], cfg[5], 2'b00}; // function set
		end else if (cnt_nxt < DCTL_END_CYC) begin
			step_ofs  = cnt_nxt - FSET_END_CYC;
			step_byte = {5'b00001, cfg[4], cfg[3], cfg[2]}; // display on/off
		end else if (cnt_nxt < CLR_END_CYC) begin
			step_ofs  = cnt_nxt - DCTL_END_CYC;
			step_byte = 8'b0000_0001; // clear
		end else begin
			step_ofs  = cnt_nxt - CLR_END_CYC;
			step_byte = {6'b000001, cfg[1], cfg[0]}; // entry mode
		end
	end

	// outputs are registered from the next state and count
	always_comb begin
		e_nxt      = 1'b0;
		rs_nxt     = 1'b0;
		rw_nxt     = 1'b0;
		data_nxt   = '0;
		strobe_nxt = 1'b0;
		case (state_nxt)
			ST_INIT: begin
				e_nxt    = (step_ofs < INIT_PULSE_CYC);
				data_nxt = step_byte; // held over the step's wait too
			end
			ST_XFER: begin
				rs_nxt   = word_nxt[XFER_RS_BIT];
				rw_nxt   = word_nxt[XFER_RW_BIT];
				data_nxt = word_nxt[7:0];
				e_nxt    = (cnt_nxt >= XFER_SETUP_CYC) && (cnt_nxt < XFER_EHIGH_CYC);
				// last high cycle, capture lands on the falling edge
				strobe_nxt = word_nxt[XFER_RW_BIT] && (cnt_nxt == XFER_EHIGH_CYC - 1'b1);
			end
			default: begin
				e_nxt = 1'b0; // power-up and idle keep the bus quiet
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_PWRUP;
			cnt        <= '0;
			lcd_e      <= 1'b0;
			lcd_rs     <= 1'b0;
			lcd_rw     <= 1'b0;
			lcd_data   <= '0;
			busy       <= 1'b0;
			cap_strobe <= 1'b0;
		end else begin
			state      <= state_nxt;
			cnt        <= cnt_nxt;
			lcd_e      <= e_nxt;
			lcd_rs     <= rs_nxt;
			lcd_rw     <= rw_nxt;
			lcd_data   <= data_nxt;
			busy       <= (state_nxt != ST_IDLE);
			cap_strobe <= strobe_nxt;
		end
	end

endmodule

// ==== src/lcd_read_capture.sv ====
module lcd_read_capture
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cap_strobe,
	input  logic [7:0] lcd_data_in,
	output logic       rsp_valid,
	input  logic       rsp_ready,
	output logic [7:0] rsp_data,
	output logic       rsp_free
);

	logic rsp_take;

	assign rsp_take = rsp_valid && rsp_ready;

	// empty now, or emptied by this cycle's handshake
	assign rsp_free = !rsp_valid || rsp_take;

	always_ff @(posedge clk) begin
		if (cap_strobe) begin
			rsp_data <= lcd_data_in; // panel byte at enable fall
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else if (cap_strobe) begin
			rsp_valid <= 1'b1; // new capture wins over a handshake
		end else if (rsp_take) begin
			rsp_valid <= 1'b0;
		end
	end

endmodule

// ==== src/lcd_text_display.sv ====
module lcd_text_display
	import lcd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [CFG_W-1:0]  cfg,
	input  logic              xfer_valid,
	output logic              xfer_ready,
	input  logic [XFER_W-1:0] xfer_word,
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output logic [7:0]        rsp_data,
	output logic              busy,
	output logic              lcd_e,
	output logic              lcd_rs,
	output logic              lcd_rw,
	output logic [7:0]        lcd_data,
	input  logic [7:0]        lcd_data_in
);

	logic              q_valid;
	logic              q_ready;
	logic [XFER_W-1:0] q_word;
	logic              rsp_free;
	logic              cap_strobe;

	lcd_cmd_queue i_cmd_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.xfer_valid (xfer_valid),
		.xfer_word  (xfer_word),
		.xfer_ready (xfer_ready),
		.q_valid    (q_valid),
		.q_ready    (q_ready),
		.q_word     (q_word)
	);

	lcd_bus_timing i_bus_timing (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.q_valid    (q_valid),
		.q_ready    (q_ready),
		.q_word     (q_word),
		.rsp_free   (rsp_free),
		.lcd_e      (lcd_e),
		.lcd_rs     (lcd_rs),
		.lcd_rw     (lcd_rw),
		.lcd_data   (lcd_data),
		.busy       (busy),
		.cap_strobe (cap_strobe)
	);

	lcd_read_capture i_read_capture (
		.clk         (clk),
		.rst_n       (rst_n),
		.cap_strobe  (cap_strobe),
		.lcd_data_in (lcd_data_in),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_data    (rsp_data),
		.rsp_free    (rsp_free)
	);

endmodule

// ==== testbench/lcd_text_display_assert.sv ====
module lcd_text_display_assert
	import lcd_pkg::*;
(
	input logic            clk,
	input logic            rst_n,
	input logic            lcd_e,
	input logic            lcd_rs,
	input logic            lcd_rw,
	input logic [7:0]      lcd_data,
	input logic            busy,
	input logic            cap_strobe,
	input logic            q_valid,
	input logic [ST_W-1:0] state
);

	assert property (@(posedge clk) disable iff (!rst_n) lcd_e |-> busy)
		else $error("lcd_e high while busy is low");

	// bus must not move inside a pulse
	assert property (@(posedge clk) disable iff (!rst_n)
		(lcd_e && $past(lcd_e)) |-> $stable({lcd_rs, lcd_rw, lcd_data}))
		else $error("rs, rw or data changed while lcd_e high");

	// strobe sits on the last high cycle of a read pulse
	assert property (@(posedge clk) disable iff (!rst_n)
		cap_strobe |-> (lcd_e && lcd_rw) ##1 !lcd_e)
		else $error("cap_strobe outside the last high cycle of a read pulse");

	assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE && !q_valid) |=> (state == ST_IDLE))
		else $error("left idle with no queued word");

endmodule

bind lcd_bus_timing lcd_text_display_assert i_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.lcd_e      (lcd_e),
	.lcd_rs     (lcd_rs),
	.lcd_rw     (lcd_rw),
	.lcd_data   (lcd_data),
	.busy       (busy),
	.cap_strobe (cap_strobe),
	.q_valid    (q_valid),
	.state      (state)
);

// ==== testbench/lcd_text_display_tb.sv ====
module lcd_text_display_tb
	import lcd_pkg::*;
;

	logic              clk;
	logic              rst_n;
	logic [CFG_W-1:0]  cfg;
	logic              xfer_valid;
	logic              xfer_ready;
	logic [XFER_W-1:0] xfer_word;
	logic              rsp_valid;
	logic              rsp_ready;
	logic [7:0]        rsp_data;
	logic              busy;
	logic              lcd_e;
	logic              lcd_rs;
	logic              lcd_rw;
	logic [7:0]        lcd_data;
	logic [7:0]        lcd_data_in;

	logic [9:0] exp_bus [64]; // rs, rw, data per transfer
	logic [7:0] ret_byte [64];
	int         stall [64];
	int         n_xfer = 0;
	int         n_reads = 0;
	int         stall_sum = 0;
	int         cyc = 0;
	int         limit = 0;
	int         init_pulses = 0;
	int         xfer_pulses = 0;
	int         reads_done = 0;
	int         accepted = 0;
	int         taken = 0;
	int         e_width = 0;
	int         last_rise = 0;
	logic       e_q = 1'b0;
	logic       busy_q = 1'b0;
	logic       init_done = 1'b0;
	logic       saw_full = 1'b0;
	integer     seed = 90;

	lcd_text_display i_lcd_text_display (.*);

	// panel answers only during a read pulse
	assign lcd_data_in = (lcd_e && lcd_rw && xfer_pulses < n_xfer) ?
		ret_byte[xfer_pulses] : 8'h00;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg,
				actual, expected);
			$display("TB FAILED");
			$fatal(1, "check mismatch");
		end
	endtask

	function automatic logic [7:0] init_byte(input int step);
		case (step)
			0:       return {4'b0011, cfg[6:5], 2'b00}; // function set
			1:       return {5'b00001, cfg[4:2]};       // display control
			2:       return 8'h01;
			default: return {6'b000001, cfg[1:0]};     // entry mode
		endcase
	endfunction

	task automatic load_stim();
		int    fd;
		int    got;
		string line;
		logic [31:0] rs, rw, data, ret;
		int    st;
		fd = $fopen("testbench/lcd_text_display_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("TB FAILED");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			got = $fgets(line, fd);
			if (got > 0 && line[0] != "#") begin
				if ($sscanf(line, "%h %h %h %h %d", rs, rw, data, ret, st) == 5) begin
					exp_bus[n_xfer]  = {rs[0], rw[0], data[7:0]};
					ret_byte[n_xfer] = ret[7:0];
					stall[n_xfer]    = st;
					stall_sum += st;
					if (rw[0]) n_reads++;
					n_xfer++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_transfers();
		for (int i = 0; i < n_xfer; i++) begin
			xfer_word  = exp_bus[i];
			xfer_valid = 1'b1;
			@(negedge clk);
			while (!xfer_ready) @(negedge clk); // held until accepted
			@(posedge clk);
			#10;
		end
		xfer_valid = 1'b0;
	endtask

	task automatic serve_responses();
		int jitter;
		for (int i = 0; i < n_xfer; i++) begin
			if (exp_bus[i][8]) begin
				@(negedge clk);
				while (!rsp_valid) @(negedge clk);
				jitter = $unsigned($random(seed)) % 4;
				repeat (stall[i] + jitter) @(posedge clk);
				@(posedge clk);
				#10 rsp_ready = 1'b1;
				@(negedge clk);
				check_value(rsp_valid, 1, "response dropped before handshake");
				check_value(rsp_data, ret_byte[i], "read response byte");
				@(posedge clk);
				#10 rsp_ready = 1'b0;
				check_value(rsp_valid, 0, "response still valid after handshake");
				reads_done++;
			end
		end
	endtask

	// panel model and bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (busy && !busy_q && init_done) taken++;
			if (!busy && busy_q) init_done = 1'b1;
			check_value(xfer_ready, (accepted - taken) != QUEUE_DEPTH,
				"xfer_ready vs queue level");
			if (!xfer_ready) saw_full = 1'b1;
			if (xfer_valid && xfer_ready) accepted++;
			if (lcd_e && !e_q) begin
				e_width = 0;
				if (init_pulses == 0)
					check_value(cyc >= POWERUP_US * CLK_PER_US, 1, "pulse before power-up end");
				if (init_pulses == 4) begin
					if (xfer_pulses > 0)
						check_value(cyc - last_rise >= XFER_HOLD_US * CLK_PER_US, 1,
							"pulse spacing");
					last_rise = cyc;
					if (lcd_rw) check_value(rsp_valid, 0, "read pulse while response held");
				end
			end
			if (lcd_e) e_width++;
			if (!lcd_e && e_q) begin
				if (init_pulses < 4) begin
					check_value(e_width, INIT_PULSE_US * CLK_PER_US, "init enable width");
					check_value({lcd_rs, lcd_rw, lcd_data}, {2'b00, init_byte(init_pulses)},
						"init byte");
					init_pulses++;
				end else begin
					check_value(e_width, (XFER_EHIGH_US - XFER_SETUP_US) * CLK_PER_US,
						"transfer enable width");
					if (xfer_pulses < n_xfer)
						check_value({lcd_rs, lcd_rw, lcd_data}, exp_bus[xfer_pulses],
							"transfer bus");
					if (lcd_rw) check_value(rsp_valid, 1, "no response at enable fall");
					xfer_pulses++;
				end
			end
			e_q    = lcd_e;
			busy_q = busy;
		end
	end

	always @(posedge clk) begin
		if (rst_n) cyc = cyc + 1;
		if (limit > 0 && cyc > limit) begin
			$display("the run timed out after %0d cycles", cyc);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst_n      = 1'b0;
		cfg        = 7'b10_111_10; // 2 lines, display/cursor/blink on, increment
		xfer_valid = 1'b0;
		xfer_word  = '0;
		rsp_ready  = 1'b0;
		load_stim();
		limit = (POWERUP_US + 4 * INIT_PULSE_US + WAIT_FSET_US + WAIT_DCTL_US + WAIT_CLR_US
			+ WAIT_ENTRY_US) * CLK_PER_US + n_xfer * 1000 + stall_sum + 4 * n_xfer + 2000;
		repeat (3) @(posedge clk);
		#10 rst_n = 1'b1;
		fork
			drive_transfers();
			serve_responses();
		join
		while (xfer_pulses < n_xfer) @(negedge clk);
		repeat (XFER_HOLD_US * CLK_PER_US + 100) @(negedge clk); // room for a stray pulse
		check_value(xfer_pulses, n_xfer, "transfer pulse count");
		check_value(reads_done, n_reads, "read responses");
		check_value(saw_full, 1, "xfer_ready never dropped");
		check_value(busy, 0, "busy after last transfer");
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== lcd_text_display.f ====
src/lcd_pkg.sv
src/lcd_cmd_queue.sv
src/lcd_bus_timing.sv
src/lcd_read_capture.sv
src/lcd_text_display.sv
testbench/lcd_text_display_assert.sv
testbench/lcd_text_display_tb.sv

// ==== testbench/lcd_text_display_stim.txt ====
# rs rw data ret stall : rs, rw, data byte and panel read byte in hex
# stall is the rsp_ready hold-off in clock cycles, decimal
1 0 48 00 0
1 0 69 00 0
0 0 80 00 0
1 1 00 5a 2500
1 1 00 c3 5
1 0 41 00 0
1 0 42 00 0
1 0 43 00 0
1 0 44 00 0
0 1 00 85 12
1 0 21 00 0
0 0 c0 00 0
1 1 00 3e 0
